// ==== verilog/muldiv_pkg.sv ====
// Shared types, operation codes and constants of the RV64 multiply/divide unit
`default_nettype none

package muldiv_pkg;

    // One operand or result word of the 64-bit datapath
    typedef logic [63:0] xlen_t;

    // Destination register index that travels with a request and comes back with its result
    typedef logic [4:0] tag_t;

    // Bit 3 marks a word (W) operation and bits 2:0 hold funct3
    // Funct3 bit 2 picks the divider, then bit 0 is unsigned and bit 1 is remainder
    typedef logic [3:0] muldiv_op_t;

    // Multiply operations, funct3 000 to 011
    localparam muldiv_op_t OP_MUL    = 4'b0000;
    localparam muldiv_op_t OP_MULH   = 4'b0001;
    localparam muldiv_op_t OP_MULHSU = 4'b0010;
    localparam muldiv_op_t OP_MULHU  = 4'b0011;

    // Divide and remainder operations, funct3 100 to 111
    localparam muldiv_op_t OP_DIV    = 4'b0100;
    localparam muldiv_op_t OP_DIVU   = 4'b0101;
    localparam muldiv_op_t OP_REM    = 4'b0110;
    localparam muldiv_op_t OP_REMU   = 4'b0111;

    // Register stages inside the multiplier, from request to its own result valid
    localparam int MUL_LATENCY = 3;

    // Divider control states
    typedef enum logic [1:0] {
        IDLE,
        CALCULATE,
        OUTPUT
    } div_state_t;

endpackage

`default_nettype wire

// ==== verilog/mul_unit.sv ====
// Three-stage pipelined 64x64 multiplier for MUL, MULH, MULHSU, MULHU and MULW
`timescale 1ns/100ps
`default_nettype none

module mul_unit #(
    parameter int TAG_WIDTH = 5
) (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         req_valid,
    output logic                        req_ready,
    input  wire muldiv_pkg::muldiv_op_t req_op,
    input  wire [TAG_WIDTH-1:0]         req_tag,
    input  wire muldiv_pkg::xlen_t      operand1,
    input  wire muldiv_pkg::xlen_t      operand2,
    output logic                        resp_valid,
    input  wire                         resp_ready,
    output muldiv_pkg::xlen_t           resp_result,
    output logic [TAG_WIDTH-1:0]        resp_tag
);

    import muldiv_pkg::*;

    // Valid bit per stage, the top bit belongs to the result stage
    logic [MUL_LATENCY-1:0] stage_valid;
    logic                   advance;

    // Stage 1, operands sign-extended to 65 bits
    logic                   a_signed;
    logic                   b_signed;
    logic [64:0]            s1_a;
    logic [64:0]            s1_b;
    muldiv_op_t             s1_op;
    logic [TAG_WIDTH-1:0]   s1_tag;

    // Stage 2, partial products of the 33-bit low and 32-bit high slices
    logic        [65:0]     s2_ll;
    logic signed [65:0]     s2_hl;
    logic signed [65:0]     s2_lh;
    logic signed [63:0]     s2_hh;
    muldiv_op_t             s2_op;
    logic [TAG_WIDTH-1:0]   s2_tag;

    // Stage 3, full product and selected result word
    logic [129:0]           product;
    xlen_t                  result;
    logic [TAG_WIDTH-1:0]   s3_tag;

    // The whole pipe freezes only when a finished result cannot leave
    assign advance   = !(stage_valid[MUL_LATENCY-1] && !resp_ready);
    assign req_ready = advance;

    // MULH treats both operands as signed, MULHSU only the first one
    // For MUL and MULW the low product bits do not depend on signedness
    always_comb begin
        a_signed = (req_op[2:0] == OP_MULH[2:0]) || (req_op[2:0] == OP_MULHSU[2:0]);
        b_signed = (req_op[2:0] == OP_MULH[2:0]);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stage_valid <= '0;
        end else if (advance) begin
            stage_valid <= {stage_valid[MUL_LATENCY-2:0], req_valid};
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            s1_a   <= {a_signed & operand1[63], operand1};
            s1_b   <= {b_signed & operand2[63], operand2};
            s1_op  <= req_op;
            s1_tag <= req_tag;
        end
    end

    // Each 65-bit operand splits into an unsigned low part of 33 bits
    // and a signed high part of 32 bits weighted by 2^33
    always_ff @(posedge clk) begin
        if (advance) begin
            s2_ll  <= s1_a[32:0] * s1_b[32:0];
            s2_hl  <= $signed(s1_a[64:33]) * $signed({1'b0, s1_b[32:0]});
            s2_lh  <= $signed({1'b0, s1_a[32:0]}) * $signed(s1_b[64:33]);
            s2_hh  <= $signed(s1_a[64:33]) * $signed(s1_b[64:33]);
            s2_op  <= s1_op;
            s2_tag <= s1_tag;
        end
    end

    // Partial products are aligned and summed in 130-bit two's complement
    always_comb begin
        product = {64'b0, s2_ll}
                + {{31{s2_hl[65]}}, s2_hl, 33'b0}
                + {{31{s2_lh[65]}}, s2_lh, 33'b0}
                + {s2_hh, 66'b0};
    end

    always_comb begin
        if (s2_op[3]) begin
            // MULW keeps the low word and sign-extends it
            result = {{32{product[31]}}, product[31:0]};
        end else if (s2_op[2:0] == OP_MUL[2:0]) begin
            result = product[63:0];
        end else begin
            // MULH, MULHSU and MULHU return the upper half
            result = product[127:64];
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            resp_result <= result;
            s3_tag      <= s2_tag;
        end
    end

    assign resp_valid = stage_valid[MUL_LATENCY-1];
    assign resp_tag   = s3_tag;

endmodule

`default_nettype wire

// ==== verilog/div_unit.sv ====
// Iterative restoring divider for the RV64 divide and remainder operations
`timescale 1ns/100ps
`default_nettype none

module div_unit #(
    parameter int TAG_WIDTH = 5
) (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         req_valid,
    output logic                        req_ready,
    input  wire muldiv_pkg::muldiv_op_t req_op,
    input  wire [TAG_WIDTH-1:0]         req_tag,
    input  wire muldiv_pkg::xlen_t      operand1,
    input  wire muldiv_pkg::xlen_t      operand2,
    output logic                        resp_valid,
    input  wire                         resp_ready,
    output muldiv_pkg::xlen_t           resp_result,
    output logic [TAG_WIDTH-1:0]        resp_tag
);

    import muldiv_pkg::*;

    // Decoded request fields
    logic                 op_unsigned;
    logic                 op_rem;
    logic                 op_word;

    // Signs and magnitudes for both operand widths
    logic                 a_sign_64;
    logic                 b_sign_64;
    logic                 a_sign_32;
    logic                 b_sign_32;
    xlen_t                a_mag_64;
    xlen_t                b_mag_64;
    xlen_t                a_ext;
    xlen_t                b_ext;
    xlen_t                a_mag_32;
    xlen_t                b_mag_32;

    // Selected inputs to the loop
    logic                 a_sign;
    logic                 b_sign;
    xlen_t                a_mag;
    xlen_t                b_mag;
    xlen_t                a_rev;
    logic                 fast_path;

    // Iteration state
    div_state_t           state;
    logic [5:0]           loop_cnt;
    xlen_t                dividend_bits;
    xlen_t                divisor;
    xlen_t                quo;
    xlen_t                rem;
    xlen_t                rem_shift;
    logic                 quo_neg;
    logic                 rem_neg;
    logic                 word_reg;
    logic                 rem_reg;
    logic [TAG_WIDTH-1:0] tag_reg;
    xlen_t                result_64;

    assign op_unsigned = req_op[0];
    assign op_rem      = req_op[1];
    assign op_word     = req_op[3];

    assign a_sign_64 = op_unsigned ? 1'b0 : operand1[63];
    assign b_sign_64 = op_unsigned ? 1'b0 : operand2[63];
    assign a_sign_32 = op_unsigned ? 1'b0 : operand1[31];
    assign b_sign_32 = op_unsigned ? 1'b0 : operand2[31];

    assign a_mag_64 = a_sign_64 ? -operand1 : operand1;
    assign b_mag_64 = b_sign_64 ? -operand2 : operand2;

    // Word operations look only at the low halves, extended by their own sign
    assign a_ext    = {{32{a_sign_32}}, operand1[31:0]};
    assign b_ext    = {{32{b_sign_32}}, operand2[31:0]};
    assign a_mag_32 = a_sign_32 ? -a_ext : a_ext;
    assign b_mag_32 = b_sign_32 ? -b_ext : b_ext;

    assign a_sign = op_word ? a_sign_32 : a_sign_64;
    assign b_sign = op_word ? b_sign_32 : b_sign_64;
    assign a_mag  = op_word ? a_mag_32 : a_mag_64;
    assign b_mag  = op_word ? b_mag_32 : b_mag_64;

    // Half the iterations are enough when both magnitudes fit in 32 bits
    // A zero 64-bit divisor stays on the long loop so its quotient fills all 64 bits
    assign fast_path = op_word ||
                       ((a_mag_64[63:32] == 32'b0) && (b_mag_64[63:32] == 32'b0) &&
                        (b_mag_64 != '0));

    // The dividend is fed into the loop LSB first, so reverse it once up front
    always_comb begin
        a_rev = '0;
        if (fast_path) begin
            for (int i = 0; i < 32; i++) begin
                a_rev[i] = a_mag[31-i];
            end
        end else begin
            for (int i = 0; i < 64; i++) begin
                a_rev[i] = a_mag[63-i];
            end
        end
    end

    assign req_ready = (state == IDLE);
    assign rem_shift = {rem[62:0], dividend_bits[0]};

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (req_valid) begin
                        state <= CALCULATE;
                    end
                end
                CALCULATE: begin
                    if (loop_cnt == 6'd0) begin
                        state <= OUTPUT;
                    end
                end
                OUTPUT: begin
                    // Hold the result until the collector takes it
                    if (resp_ready) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_ready && req_valid) begin
            loop_cnt      <= fast_path ? 6'd31 : 6'd63;
            quo           <= '0;
            rem           <= '0;
            dividend_bits <= a_rev;
            divisor       <= b_mag;
            // No sign fix on a zero divisor, which leaves an all-ones quotient
            quo_neg       <= (a_sign ^ b_sign) && (b_mag != '0);
            rem_neg       <= a_sign;
            word_reg      <= op_word;
            rem_reg       <= op_rem;
            tag_reg       <= req_tag;
        end else if (state == CALCULATE) begin
            dividend_bits <= {1'b0, dividend_bits[63:1]};
            loop_cnt      <= loop_cnt - 6'd1;
            if (rem_shift >= divisor) begin
                rem <= rem_shift - divisor;
                quo <= {quo[62:0], 1'b1};
            end else begin
                rem <= rem_shift;
                quo <= {quo[62:0], 1'b0};
            end
        end
    end

    // Signed overflow needs no special case, negating 2^63 wraps back to itself
    assign result_64 = rem_reg ? (rem_neg ? -rem : rem) : (quo_neg ? -quo : quo);

    assign resp_valid  = (state == OUTPUT);
    assign resp_result = word_reg ? {{32{result_64[31]}}, result_64[31:0]} : result_64;
    assign resp_tag    = tag_reg;

endmodule

`default_nettype wire

// ==== verilog/muldiv_resp_collect.sv ====
// Response merge of the multiplier and divider into one registered output with back-pressure
`timescale 1ns/100ps
`default_nettype none

module muldiv_resp_collect #(
    parameter int TAG_WIDTH = 5
) (
    input  wire                    clk,
    input  wire                    rst,
    // Multiplier result stream
    input  wire                    mul_valid,
    output logic                   mul_ready,
    input  wire muldiv_pkg::xlen_t mul_result,
    input  wire [TAG_WIDTH-1:0]    mul_tag,
    // Divider result stream
    input  wire                    div_valid,
    output logic                   div_ready,
    input  wire muldiv_pkg::xlen_t div_result,
    input  wire [TAG_WIDTH-1:0]    div_tag,
    // Merged response
    output logic                   resp_valid,
    input  wire                    resp_ready,
    output muldiv_pkg::xlen_t      resp_result,
    output logic [TAG_WIDTH-1:0]   resp_tag
);

    logic load_en;

    // The output register takes new data when it is empty or drains this cycle
    assign load_en = !resp_valid || resp_ready;

    // Divider wins a tie, since it blocks its own request port while it waits
    assign div_ready = load_en && div_valid;
    assign mul_ready = load_en && mul_valid && !div_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid <= 1'b0;
        end else if (load_en) begin
            resp_valid <= div_valid || mul_valid;
        end
    end

    // Result and tag stay put while the sink stalls
    always_ff @(posedge clk) begin
        if (div_ready) begin
            resp_result <= div_result;
            resp_tag    <= div_tag;
        end else if (mul_ready) begin
            resp_result <= mul_result;
            resp_tag    <= mul_tag;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/muldiv_unit.sv ====
// Multiply/divide execution unit top level, steering requests and merging the two result streams
`timescale 1ns/100ps
`default_nettype none

module muldiv_unit #(
    parameter int TAG_WIDTH = 5
) (
    input  wire                         clk,
    input  wire                         rst,
    // Request side
    input  wire                         req_valid,
    output logic                        req_ready,
    input  wire muldiv_pkg::muldiv_op_t req_op,
    input  wire [TAG_WIDTH-1:0]         req_tag,
    input  wire muldiv_pkg::xlen_t      operand1,
    input  wire muldiv_pkg::xlen_t      operand2,
    // Response side
    output logic                        resp_valid,
    input  wire                         resp_ready,
    output muldiv_pkg::xlen_t           resp_result,
    output logic [TAG_WIDTH-1:0]        resp_tag
);

    import muldiv_pkg::*;

    logic                 is_div;

    logic                 mul_req_valid;
    logic                 mul_req_ready;
    logic                 mul_resp_valid;
    logic                 mul_resp_ready;
    xlen_t                mul_resp_result;
    logic [TAG_WIDTH-1:0] mul_resp_tag;

    logic                 div_req_valid;
    logic                 div_req_ready;
    logic                 div_resp_valid;
    logic                 div_resp_ready;
    xlen_t                div_resp_result;
    logic [TAG_WIDTH-1:0] div_resp_tag;

    // Funct3 bit 2 separates divide from multiply
    assign is_div = req_op[2];

    // Only the selected unit sees the valid, and its ready goes back to the source
    assign mul_req_valid = req_valid && !is_div;
    assign div_req_valid = req_valid && is_div;
    assign req_ready     = is_div ? div_req_ready : mul_req_ready;

    mul_unit #(
        .TAG_WIDTH   (TAG_WIDTH)
    ) u_mul (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (mul_req_valid),
        .req_ready   (mul_req_ready),
        .req_op      (req_op),
        .req_tag     (req_tag),
        .operand1    (operand1),
        .operand2    (operand2),
        .resp_valid  (mul_resp_valid),
        .resp_ready  (mul_resp_ready),
        .resp_result (mul_resp_result),
        .resp_tag    (mul_resp_tag)
    );

    div_unit #(
        .TAG_WIDTH   (TAG_WIDTH)
    ) u_div (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (div_req_valid),
        .req_ready   (div_req_ready),
        .req_op      (req_op),
        .req_tag     (req_tag),
        .operand1    (operand1),
        .operand2    (operand2),
        .resp_valid  (div_resp_valid),
        .resp_ready  (div_resp_ready),
        .resp_result (div_resp_result),
        .resp_tag    (div_resp_tag)
    );

    muldiv_resp_collect #(
        .TAG_WIDTH   (TAG_WIDTH)
    ) u_collect (
        .clk         (clk),
        .rst         (rst),
        .mul_valid   (mul_resp_valid),
        .mul_ready   (mul_resp_ready),
        .mul_result  (mul_resp_result),
        .mul_tag     (mul_resp_tag),
        .div_valid   (div_resp_valid),
        .div_ready   (div_resp_ready),
        .div_result  (div_resp_result),
        .div_tag     (div_resp_tag),
        .resp_valid  (resp_valid),
        .resp_ready  (resp_ready),
        .resp_result (resp_result),
        .resp_tag    (resp_tag)
    );

endmodule

`default_nettype wire

// ==== verif/tb_muldiv_sva.sv ====
// Concurrent protocol and latency checks on the multiply/divide unit, attached by bind
`timescale 1ns/100ps
`default_nettype none

module muldiv_sva #(
    parameter int TAG_WIDTH = 5
) (
    input wire                         clk,
    input wire                         rst,
    input wire                         req_valid,
    input wire                         req_ready,
    input wire muldiv_pkg::muldiv_op_t req_op,
    input wire [TAG_WIDTH-1:0]         req_tag,
    input wire                         resp_valid,
    input wire                         resp_ready,
    input wire muldiv_pkg::xlen_t      resp_result,
    input wire [TAG_WIDTH-1:0]         resp_tag,
    input wire                         div_valid
);

    import muldiv_pkg::*;

    logic mul_accept;
    logic mul_clear;

    // A multiply enters the pipe on this edge
    assign mul_accept = req_valid && req_ready && !req_op[2];
    // Nothing holds a multiply back when the sink takes data and the divider is not competing
    assign mul_clear = resp_ready && !div_valid;

    // The output register comes out of reset empty
    a_reset_idle: assert property (@(posedge clk) rst |=> !resp_valid)
        else $error("resp_valid is high in the cycle after reset");

    // A waiting response keeps its data and tag until the sink takes it
    a_resp_stable: assert property (@(posedge clk) disable iff (rst)
        (resp_valid && !resp_ready) |=>
            (resp_valid && $stable(resp_result) && $stable(resp_tag)))
        else $error("response changed while stalled by resp_ready");

    // Uncontested and unstalled, a multiply shows up one register after the pipe
    a_mul_latency: assert property (@(posedge clk) disable iff (rst)
        ($past(mul_accept, MUL_LATENCY + 1) && $past(mul_clear, 3) &&
         $past(mul_clear, 2) && $past(mul_clear, 1)) |->
            (resp_valid && resp_tag == $past(req_tag, MUL_LATENCY + 1)))
        else $error("multiply response missing four cycles after acceptance");

endmodule

bind muldiv_unit muldiv_sva #(
    .TAG_WIDTH   (TAG_WIDTH)
) u_sva (
    .clk         (clk),
    .rst         (rst),
    .req_valid   (req_valid),
    .req_ready   (req_ready),
    .req_op      (req_op),
    .req_tag     (req_tag),
    .resp_valid  (resp_valid),
    .resp_ready  (resp_ready),
    .resp_result (resp_result),
    .resp_tag    (resp_tag),
    .div_valid   (div_resp_valid)
);

`default_nettype wire

// ==== verif/tb_muldiv.sv ====
// Testbench for the multiply/divide unit with a tag scoreboard and a RISC-V reference model
`timescale 1ns/100ps
`default_nettype none

module tb_muldiv;

    import muldiv_pkg::*;

    localparam int         TIMEOUT = 200;
    localparam muldiv_op_t OP_MULW = 4'b1000;

    logic        clk = 1'b0;
    logic        rst;
    logic        req_valid;
    logic        req_ready;
    muldiv_op_t  req_op;
    tag_t        req_tag;
    xlen_t       operand1;
    xlen_t       operand2;
    logic        resp_valid;
    logic        resp_ready = 1'b0;
    xlen_t       resp_result;
    tag_t        resp_tag;

    // Scoreboard with one slot per tag
    logic        pending [32];
    xlen_t       exp_result [32];
    int          arrival_order [32];
    int          received;
    tag_t        next_tag;
    logic        stall_en;
    logic [31:0] rng_state;
    logic [31:0] stall_state;

    muldiv_unit #(
        .TAG_WIDTH   (5)
    ) UUT (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .req_op      (req_op),
        .req_tag     (req_tag),
        .operand1    (operand1),
        .operand2    (operand2),
        .resp_valid  (resp_valid),
        .resp_ready  (resp_ready),
        .resp_result (resp_result),
        .resp_tag    (resp_tag)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Operands lean toward zero, all ones, the most negative value and small numbers
    function automatic xlen_t pick_operand();
        logic [31:0] r;
        r = next_rand();
        case (r[2:0])
            3'd0: return '0;
            3'd1: return '1;
            3'd2: return 64'h8000_0000_0000_0000;
            3'd3: return {59'b0, r[7:3]};
            3'd4: return -{59'b0, r[7:3]};
            3'd5: return {32'b0, next_rand()};
            default: return {next_rand(), next_rand()};
        endcase
    endfunction

    // Operand corners are zero, one, -1, both extremes, the word minimum and small values
    function automatic xlen_t edge_val(input int i);
        case (i)
            0: return 64'h0;
            1: return 64'h1;
            2: return '1;
            3: return 64'h8000_0000_0000_0000;
            4: return 64'h7fff_ffff_ffff_ffff;
            5: return 64'hffff_ffff_8000_0000;
            6: return 64'd7;
            default: return 64'hffff_ffff_ffff_fffd;
        endcase
    endfunction

    // Index 0 to 4 are the multiplies with MULW last, and 5 to 12 the divides with word forms after 8
    function automatic muldiv_op_t op_by_index(input int k);
        int m;
        m = k - 5;
        case (k)
            0: return OP_MUL;
            1: return OP_MULH;
            2: return OP_MULHSU;
            3: return OP_MULHU;
            4: return OP_MULW;
            default: return {m[2], 1'b1, m[1:0]};
        endcase
    endfunction

    // RISC-V M semantics computed in wide signed arithmetic
    function automatic xlen_t ref_result(input muldiv_op_t op, input xlen_t a, input xlen_t b);
        logic signed [127:0] a_s;
        logic signed [127:0] b_s;
        logic signed [127:0] b_u;
        logic [127:0]        p;
        logic signed [63:0]  x;
        logic signed [63:0]  y;
        xlen_t               r;
        a_s = $signed({{64{a[63]}}, a});
        b_s = $signed({{64{b[63]}}, b});
        b_u = $signed({64'b0, b});
        if (!op[2]) begin
            if (op[3]) begin
                p = a_s * b_s;
                return {{32{p[31]}}, p[31:0]};
            end
            case (op[1:0])
                2'b00: p = a_s * b_s;
                2'b01: p = a_s * b_s;
                2'b10: p = a_s * b_u;
                default: p = $unsigned({64'b0, a}) * $unsigned({64'b0, b});
            endcase
            return (op[1:0] == 2'b00) ? p[63:0] : p[127:64];
        end
        // Word divides run on the extended low halves and wrap back to 32 bits
        x = a;
        y = b;
        if (op[3]) begin
            x = op[0] ? {32'b0, a[31:0]} : {{32{a[31]}}, a[31:0]};
            y = op[0] ? {32'b0, b[31:0]} : {{32{b[31]}}, b[31:0]};
        end
        case (op[1:0])
            2'b00: begin
                if (y == 0) r = '1;
                else if (x == {1'b1, 63'b0} && y == -1) r = x;
                else r = x / y;
            end
            2'b01: begin
                if (y == 0) r = '1;
                else r = $unsigned(x) / $unsigned(y);
            end
            2'b10: begin
                if (y == 0) r = x;
                else if (x == {1'b1, 63'b0} && y == -1) r = '0;
                else r = x % y;
            end
            default: begin
                if (y == 0) r = x;
                else r = $unsigned(x) % $unsigned(y);
            end
        endcase
        return op[3] ? {{32{r[31]}}, r[31:0]} : r;
    endfunction

    function automatic int pending_count();
        int n;
        n = 0;
        for (int i = 0; i < 32; i++) begin
            if (pending[i]) n++;
        end
        return n;
    endfunction

    task automatic stop_on_error();
        $display("FAIL: see errors above");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic timeout_fail(input string what);
        $display("Timed out after %0d cycles waiting for %s", TIMEOUT, what);
        stop_on_error();
    endtask

    // Presents one request, waits for its acceptance and files the expected result
    task automatic send(input muldiv_op_t op, input xlen_t a, input xlen_t b, output tag_t used);
        int cnt;
        cnt = 0;
        while (pending[next_tag]) begin
            req_valid <= 1'b0;
            @(posedge clk);
            cnt++;
            if (cnt > TIMEOUT) timeout_fail("a free tag");
        end
        req_valid <= 1'b1;
        req_op    <= op;
        req_tag   <= next_tag;
        operand1  <= a;
        operand2  <= b;
        cnt = 0;
        @(posedge clk);
        while (!req_ready) begin
            cnt++;
            if (cnt > TIMEOUT) timeout_fail("req_ready");
            @(posedge clk);
        end
        exp_result[next_tag] = ref_result(op, a, b);
        pending[next_tag] = 1'b1;
        used = next_tag;
        next_tag = next_tag + 1'b1;
    endtask

    task automatic wait_drain();
        int cnt;
        cnt = 0;
        req_valid <= 1'b0;
        while (pending_count() != 0) begin
            @(posedge clk);
            cnt++;
            if (cnt > TIMEOUT) timeout_fail("all responses to return");
        end
    endtask

    // The response side checks each accepted result and drives random stalls
    always @(posedge clk) begin
        if (rst) begin
            resp_ready <= 1'b0;
        end else begin
            if (resp_valid && resp_ready) begin
                assert (pending[resp_tag]) else begin
                    $display("Response with tag %0d arrived but no request with it is in flight",
                             resp_tag);
                    stop_on_error();
                end
                assert (resp_result == exp_result[resp_tag]) else begin
                    $display("ERR time %0t resp_result got %h expected %h tag %0d",
                             $time, resp_result, exp_result[resp_tag], resp_tag);
                    stop_on_error();
                end
                pending[resp_tag] = 1'b0;
                received++;
                arrival_order[resp_tag] = received;
            end
            stall_state = xorshift32(stall_state);
            resp_ready <= stall_en ? (stall_state[1:0] != 2'b00) : 1'b1;
        end
    end

    initial begin
        tag_t       t;
        tag_t       div_tag;
        tag_t       last_tag;
        muldiv_op_t op;
        xlen_t      a;
        xlen_t      b;
        rst         = 1'b1;
        req_valid   = 1'b0;
        req_op      = '0;
        req_tag     = '0;
        operand1    = '0;
        operand2    = '0;
        rng_state   = 32'hdcaa_651e;
        stall_state = ~32'hdcaa_651e;
        stall_en    = 1'b0;
        received    = 0;
        next_tag    = '0;
        for (int i = 0; i < 32; i++) begin
            pending[i] = 1'b0;
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        // Every operation over every pair of corner operands, including divide by zero
        // and signed overflow in both widths
        for (int k = 0; k < 13; k++) begin
            for (int i = 0; i < 8; i++) begin
                for (int j = 0; j < 8; j++) begin
                    send(op_by_index(k), edge_val(i), edge_val(j), t);
                end
            end
        end
        wait_drain();

        // Three multiplies in flight, a long divide, then more multiplies that overtake it
        send(OP_MUL, {next_rand(), next_rand()}, {next_rand(), next_rand()}, t);
        send(OP_MULHU, {next_rand(), next_rand()}, {next_rand(), next_rand()}, t);
        send(OP_MULH, {next_rand(), next_rand()}, {next_rand(), next_rand()}, t);
        assert (pending_count() >= 3) else begin
            $display("Fewer than three multiplies in flight after back-to-back issue");
            stop_on_error();
        end
        send(OP_DIV, {next_rand(), next_rand()}, 64'h1_0000_0003, div_tag);
        send(OP_MULHSU, {next_rand(), next_rand()}, {next_rand(), next_rand()}, t);
        send(OP_MULW, {next_rand(), next_rand()}, {next_rand(), next_rand()}, last_tag);
        wait_drain();
        assert (arrival_order[div_tag] > arrival_order[last_tag]) else begin
            $display("Divide result came back before the multiplies issued after it");
            stop_on_error();
        end

        // Random mix under random resp_ready stalls
        stall_en = 1'b1;
        for (int n = 0; n < 400; n++) begin
            op = next_rand() & 32'h1 ? {1'b0, 1'b0, rng_state[2:1]} : 4'b0100;
            op = rng_state[3] ? op_by_index(int'(rng_state[7:4]) % 13) : op;
            a = pick_operand();
            b = pick_operand();
            send(op, a, b, t);
        end
        stall_en = 1'b0;
        wait_drain();

        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
verilog/muldiv_pkg.sv
verilog/mul_unit.sv
verilog/div_unit.sv
verilog/muldiv_resp_collect.sv
verilog/muldiv_unit.sv
verif/tb_muldiv_sva.sv
verif/tb_muldiv.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the multiply/divide testbench with Verilator, runs it and scans the log
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f project.f --top-module tb_muldiv -o tb_muldiv

# The log decides the outcome, so a non-zero exit of the model is tolerated here
./obj_dir/tb_muldiv > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "FAIL: see errors above" "$LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi

if ! grep -q "PASS: all tests" "$LOG"; then
    echo "Simulation ended without completing"
    exit 1
fi

echo "Simulation completed cleanly"
